//--- src.f
hdl/nibble_core_pkg.sv
hdl/reg_source_mux.sv
hdl/core_regs.sv
hdl/snapshot_port.sv
hdl/shared_nibble_ram.sv
hdl/host_axil_bridge.sv
hdl/nibble_core_top.sv
dv/nibble_core_props.sv
dv/nibble_core_tb.sv

//--- Makefile
TOP = nibble_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o sim_bin
	./obj_dir/sim_bin > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- dv/nibble_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_core_tb import nibble_core_pkg::*; ();

  localparam int LIMIT = 200;

  logic        clk;
  logic        reset;
  micro_step_t step;
  core_state_t state;
  logic [15:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [15:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  micro_step_t step_tab[$];
  core_state_t exp_tab[$];
  core_state_t exp_next;
  logic [3:0]  model [int];
  logic        host_done;

  nibble_core_top nibble_core_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_state(input core_state_t got, input core_state_t want, input string name);
    if (got !== want) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic check_nibble(input logic [3:0] got, input logic [3:0] want, input string name);
    if (got !== want) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] want, input string name);
    if (got !== want) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] want, input string name);
    if (got !== want) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, want);
      stop_run();
    end
  endtask

  function automatic micro_step_t make_step(cycle_e cyc, reg_sel_e src, reg_sel_e dst,
                                            inc_sel_e inc, logic [7:0] immed);
    micro_step_t s;
    s = '0;
    s.valid = 1'b1;
    s.cycle = cyc;
    s.src   = src;
    s.dst   = dst;
    s.inc   = inc;
    s.immed = immed;
    return s;
  endfunction

  function automatic micro_step_t alu_step(reg_sel_e src, reg_sel_e dst, logic [3:0] alu,
                                           logic zero, logic carry);
    micro_step_t s;
    s = make_step(CYCLE_WRITE, src, dst, INC_NONE, 8'h00);
    s.alu       = alu;
    s.alu_zero  = zero;
    s.alu_carry = carry;
    return s;
  endfunction

  task automatic add_row(input micro_step_t s);
    step_tab.push_back(s);
    exp_tab.push_back(exp_next);
  endtask

  // Each row lists the state expected one cycle after its step
  task automatic build_table();
    micro_step_t s;
    exp_next.a = 4'h5;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_A, INC_NONE, 8'h35));
    exp_next.b = 4'h3;
    add_row(make_step(CYCLE_WRITE, REG_IMMH, REG_B, INC_NONE, 8'h35));
    exp_next.temp_a = 4'h5;
    add_row(make_step(CYCLE_WRITE, REG_A, REG_TEMPA, INC_NONE, 8'h00));
    exp_next.temp_b = 4'hC;
    add_row(alu_step(REG_ALU, REG_TEMPB, 4'hC, 1'b0, 1'b0));
    exp_next.x = 12'h00F;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_XL, INC_NONE, 8'h0F));
    exp_next.x = 12'h0FF;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_XH, INC_NONE, 8'h0F));
    exp_next.x = 12'h3FF;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_XP, INC_NONE, 8'h03));
    exp_next.y = 12'h002;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_YL, INC_NONE, 8'h02));
    exp_next.y = 12'h012;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_YH, INC_NONE, 8'h01));
    exp_next.y = 12'h412;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_YP, INC_NONE, 8'h04));
    exp_next.sp = 8'h80;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_SPH, INC_NONE, 8'h08));
    exp_next.flags = 4'hA;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_FLAGS, INC_NONE, 8'h0A));
    exp_next.a     = 4'h7;
    exp_next.flags = 4'h9;
    add_row(alu_step(REG_ALU_WITH_FLAGS, REG_A, 4'h7, 1'b0, 1'b1));
    // Flags destination takes the ALU nibble as is
    exp_next.flags = 4'h4;
    add_row(alu_step(REG_ALU_WITH_FLAGS, REG_FLAGS, 4'h4, 1'b1, 1'b1));
    exp_next.x = 12'h300;
    add_row(make_step(CYCLE_WRITE, REG_A, REG_A, INC_XHL, 8'h00));
    exp_next.y = 12'h413;
    add_row(make_step(CYCLE_WRITE, REG_A, REG_A, INC_YHL, 8'h00));
    exp_next.sp = 8'h7F;
    add_row(make_step(CYCLE_WRITE, REG_A, REG_A, INC_SP_DEC, 8'h00));
    exp_next.sp = 8'h80;
    add_row(make_step(CYCLE_WRITE, REG_A, REG_A, INC_SP_INC, 8'h00));
    exp_next.pc = 13'h0101;
    add_row(make_step(CYCLE_FETCH, REG_A, REG_A, INC_PC, 8'h00));
    s = make_step(CYCLE_WRITE, REG_A, REG_A, INC_NONE, 8'h00);
    s.increment_pc = 1'b1;
    exp_next.pc = 13'h0102;
    add_row(s);
    exp_next.np = 5'h03;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_NPP, INC_NONE, 8'h03));
    exp_next.np = 5'h13;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_NBP, INC_NONE, 8'h01));
    exp_next.pc = 13'h1340;
    add_row(make_step(CYCLE_FETCH, REG_IMML, REG_SETPC, INC_NONE, 8'h40));
    exp_next.pc = 13'h1347;
    add_row(make_step(CYCLE_FETCH, REG_A, REG_JPBAEND, INC_NONE, 8'h00));
    exp_next.pc = 13'h1247;
    add_row(make_step(CYCLE_WRITE, REG_IMML, REG_PCP, INC_NONE, 8'h02));
    s = make_step(CYCLE_FETCH, REG_A, REG_A, INC_NONE, 8'h00);
    s.reset_np  = 1'b1;
    exp_next.np = 5'h12;
    add_row(s);
    // Stores, each followed by an idle cycle before any memory read
    model[32'h300] = 4'h6;
    add_row(make_step(CYCLE_FETCH, REG_IMML, REG_MX, INC_NONE, 8'h06));
    add_row('0);
    exp_next.b = 4'h6;
    add_row(make_step(CYCLE_WRITE, REG_MX, REG_B, INC_NONE, 8'h00));
    model[32'h413] = 4'hB;
    add_row(make_step(CYCLE_FETCH, REG_IMML, REG_MY, INC_NONE, 8'h0B));
    add_row('0);
    exp_next.temp_a = 4'hB;
    add_row(make_step(CYCLE_WRITE, REG_MY, REG_TEMPA, INC_NONE, 8'h00));
    model[32'h080] = 4'hD;
    add_row(make_step(CYCLE_FETCH, REG_IMML, REG_MSP, INC_NONE, 8'h0D));
    add_row('0);
    model[32'h07F] = 4'h2;
    add_row(make_step(CYCLE_FETCH, REG_IMML, REG_MSP_DEC, INC_NONE, 8'h02));
    add_row('0);
    exp_next.a = 4'h2;
    add_row(make_step(CYCLE_WRITE, REG_MSP_DEC, REG_A, INC_NONE, 8'h00));
    model[32'h009] = 4'h7;
    add_row(make_step(CYCLE_FETCH, REG_IMMH, REG_MN, INC_NONE, 8'h79));
    add_row('0);
    exp_next.temp_b = 4'h7;
    add_row(make_step(CYCLE_WRITE, REG_MN, REG_TEMPB, INC_NONE, 8'h09));
  endtask

  task automatic write_axi(input logic [15:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    n = 0;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      @(negedge clk);
      n++;
      if (n > LIMIT) report_timeout("no awready from the DUT");
    end while (!awready);
    if (wready !== 1'b1) begin
      $display("ERR %0t wready got %b expected 1", $time, wready);
      stop_run();
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > LIMIT) report_timeout("no write response from the DUT");
    end while (!bvalid);
    repeat ($urandom_range(3)) @(negedge clk);
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_axi(input logic [15:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    n = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(negedge clk);
      n++;
      if (n > LIMIT) report_timeout("no arready from the DUT");
    end while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > LIMIT) report_timeout("no read response from the DUT");
    end while (!rvalid);
    repeat ($urandom_range(3)) @(negedge clk);
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic pulse_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] word;
    logic [1:0]  resp;
    void'($urandom(32'h80c3_9d12));
    reset     = 1'b1;
    step      = '0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    host_done = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    exp_next    = '0;
    exp_next.pc = 13'h0100;
    exp_next.np = 5'h01;
    check_state(state, exp_next, "state after reset");
    read_axi(16'h4000, word, resp);
    check_resp(resp, 2'b00, "rresp 0x4000");
    check_word(word, {2'b00, exp_next.np, exp_next.pc, exp_next.a, exp_next.b, exp_next.flags},
               "rdata 0x4000");

    build_table();
    for (int i = 0; i < step_tab.size(); i++) begin
      step = step_tab[i];
      @(negedge clk);
      check_state(state, exp_tab[i], $sformatf("state row %0d", i));
    end
    step = '0;

    // Word 1 follows the live registers
    read_axi(16'h4000, word, resp);
    check_resp(resp, 2'b00, "rresp 0x4000 live");
    check_word(word, {2'b00, exp_next.np, exp_next.pc, exp_next.a, exp_next.b, exp_next.flags},
               "rdata 0x4000 live");

    foreach (model[a]) begin
      read_axi(16'(a * 4), word, resp);
      check_resp(resp, 2'b00, "rresp memory");
      check_nibble(word[3:0], model[a], $sformatf("rdata nibble %h", a));
    end

    // Host traffic against a core storing every other cycle
    fork
      begin
        logic [31:0] hw;
        logic [31:0] hr;
        logic [1:0]  hresp;
        for (int i = 0; i < 8; i++) begin
          hw = $urandom;
          model[32'h800 + i] = hw[3:0];
          write_axi(16'h2000 + 16'(i * 4), hw, hresp);
          check_resp(hresp, 2'b00, "bresp memory");
          read_axi(16'h2000 + 16'(i * 4), hr, hresp);
          check_resp(hresp, 2'b00, "rresp memory");
          check_word(hr, {28'h0, hw[3:0]}, "rdata memory");
        end
        host_done = 1'b1;
      end
      begin
        logic [7:0] imm;
        int         n;
        n = 0;
        while (!host_done) begin
          imm = 8'($urandom);
          model[32'(imm[3:0])] = imm[7:4];
          step = make_step(CYCLE_FETCH, REG_IMMH, REG_MN, INC_NONE, imm);
          @(negedge clk);
          step = '0;
          @(negedge clk);
          n++;
          if (n > LIMIT * 20) report_timeout("host traffic never finished");
        end
      end
    join

    foreach (model[a]) begin
      read_axi(16'(a * 4), word, resp);
      check_resp(resp, 2'b00, "rresp memory");
      check_nibble(word[3:0], model[a], $sformatf("rdata nibble %h", a));
    end
    read_axi(16'h5000, word, resp);
    check_resp(resp, 2'b10, "rresp unmapped");
    check_word(word, 32'h0, "rdata unmapped");
    write_axi(16'h4010, 32'h1234_5678, resp);
    check_resp(resp, 2'b10, "bresp unmapped");

    // Savestate reload through reset
    exp_next       = '0;
    exp_next.np    = 5'h0A;
    exp_next.pc    = 13'h0ABC;
    exp_next.a     = 4'h3;
    exp_next.b     = 4'hC;
    exp_next.flags = 4'h5;
    exp_next.x     = 12'h5A6;
    exp_next.y     = 12'h0F1;
    exp_next.sp    = 8'h3C;
    write_axi(16'h4000, {2'b00, exp_next.np, exp_next.pc, exp_next.a, exp_next.b,
                         exp_next.flags}, resp);
    check_resp(resp, 2'b00, "bresp 0x4000");
    write_axi(16'h4004, {exp_next.x, exp_next.y, exp_next.sp}, resp);
    check_resp(resp, 2'b00, "bresp 0x4004");
    pulse_reset();
    check_state(state, exp_next, "state after savestate load");
    read_axi(16'h4004, word, resp);
    check_resp(resp, 2'b00, "rresp 0x4004");
    check_word(word, {exp_next.x, exp_next.y, exp_next.sp}, "rdata 0x4004");

    write_axi(16'h4008, 32'h0000_0001, resp);
    check_resp(resp, 2'b00, "bresp 0x4008");
    read_axi(16'h4008, word, resp);
    check_resp(resp, 2'b00, "rresp 0x4008");
    check_word(word, 32'h0, "rdata 0x4008");
    pulse_reset();
    exp_next    = '0;
    exp_next.pc = 13'h0100;
    exp_next.np = 5'h01;
    check_state(state, exp_next, "state after restore");

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/nibble_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_core_props import nibble_core_pkg::*; (
  input logic        clk,
  input logic        reset,
  input micro_step_t step,
  input mem_req_t    core_req,
  input logic        store_valid,
  input logic        use_memory
);

  // The store owns the memory port for its cycle
  store_then_read: assert property (@(posedge clk) disable iff (reset)
    store_valid |-> !(step.valid && use_memory))
    else $error("memory read issued while a store is pending");

  quiet_in_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> !core_req.valid)
    else $error("core memory request active during reset");

  single_cycle_store: assert property (@(posedge clk) disable iff (reset)
    store_valid |=> !store_valid)
    else $error("store request held longer than one cycle");

endmodule

bind core_regs nibble_core_props nibble_core_props_inst (
  .clk         (clk),
  .reset       (reset),
  .step        (step),
  .core_req    (core_req),
  .store_valid (store_valid),
  .use_memory  (use_memory)
);

`default_nettype wire

//--- hdl/nibble_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_core_top import nibble_core_pkg::*; #(
  parameter int RAM_ADDR_BITS = 12
) (
  input  logic        clk,
  input  logic        reset,
  input  micro_step_t step,
  output core_state_t state,
  input  logic [15:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [15:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  mem_req_t    core_req;
  mem_req_t    host_req;
  logic [3:0]  mem_rdata;
  logic [3:0]  host_rdata;
  logic        host_grant;
  ss_bus_t     ss_bus;
  logic [31:0] ss1_out;
  logic [31:0] ss2_out;
  logic [31:0] ss_rdata;
  snap_regs1_t snap1_cur;
  snap_regs1_t snap1_new;
  snap_regs2_t snap2_cur;
  snap_regs2_t snap2_new;

  assign ss_rdata = ss1_out | ss2_out;

  core_regs core_regs_inst (
    .clk (clk), .reset (reset), .step (step),
    .snap1_new (snap1_new), .snap2_new (snap2_new),
    .mem_rdata (mem_rdata), .core_req (core_req), .state (state),
    .snap1_cur (snap1_cur), .snap2_cur (snap2_cur)
  );

  snapshot_port #(
    .payload_t (snap_regs1_t), .ADDRESS (SS_REGS1), .DEFAULT_VALUE (SNAP1_DEFAULT)
  ) snap1_port_inst (
    .clk (clk), .ss_bus (ss_bus), .current_data (snap1_cur),
    .new_data (snap1_new), .bus_out (ss1_out)
  );

  snapshot_port #(
    .payload_t (snap_regs2_t), .ADDRESS (SS_REGS2), .DEFAULT_VALUE (snap_regs2_t'(0))
  ) snap2_port_inst (
    .clk (clk), .ss_bus (ss_bus), .current_data (snap2_cur),
    .new_data (snap2_new), .bus_out (ss2_out)
  );

  shared_nibble_ram #(.RAM_ADDR_BITS (RAM_ADDR_BITS)) shared_nibble_ram_inst (
    .clk (clk), .core_req (core_req), .host_req (host_req),
    .core_rdata (mem_rdata), .host_rdata (host_rdata), .host_grant (host_grant)
  );

  host_axil_bridge #(.RAM_ADDR_BITS (RAM_ADDR_BITS)) host_axil_bridge_inst (
    .clk (clk), .reset (reset),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .host_req (host_req), .host_rdata (host_rdata), .host_grant (host_grant),
    .ss_bus (ss_bus), .ss_rdata (ss_rdata)
  );

endmodule

`default_nettype wire

//--- hdl/host_axil_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module host_axil_bridge import nibble_core_pkg::*; #(
  parameter int RAM_ADDR_BITS = 12
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [15:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  output mem_req_t    host_req,
  input  logic [3:0]  host_rdata,
  input  logic        host_grant,
  output ss_bus_t     ss_bus,
  input  logic [31:0] ss_rdata
);

  typedef enum logic [1:0] {ST_IDLE, ST_MEM, ST_RESP} bridge_state_e;

  bridge_state_e st;
  logic [15:0]   addr_q;
  logic [31:0]   wdata_q;
  logic          write_q;
  logic [1:0]    resp_q;
  logic          mem_hit;
  logic          ss_word_hit;
  logic          restore_hit;
  logic          resp_first;

  assign mem_hit     = 32'(addr_q) < (32'd1 << (RAM_ADDR_BITS + 2));
  assign ss_word_hit = addr_q == 16'h4000 || addr_q == 16'h4004;
  assign restore_hit = addr_q == 16'h4008;
  // First cycle in ST_RESP, before the response is raised
  assign resp_first  = st == ST_RESP && !bvalid && !rvalid;

  assign host_req = '{valid: st == ST_MEM, we: write_q, addr: addr_q[13:2], wdata: wdata_q[3:0]};

  assign ss_bus = '{addr: {7'b0, addr_q[2]}, wdata: wdata_q,
                    wren: resp_first && write_q && ss_word_hit,
                    restore: resp_first && write_q && restore_hit};

  assign bresp = resp_q;
  assign rresp = resp_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      st      <= ST_IDLE;
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      case (st)
        ST_IDLE: begin
          if (awready || arready) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            st      <= mem_hit ? ST_MEM : ST_RESP;
          end else if (awvalid && wvalid) begin
            awready <= 1'b1;
            wready  <= 1'b1;
            addr_q  <= awaddr;
            wdata_q <= wdata;
            write_q <= 1'b1;
          end else if (arvalid) begin
            arready <= 1'b1;
            addr_q  <= araddr;
            write_q <= 1'b0;
          end
        end
        ST_MEM: begin
          if (host_grant) begin
            st <= ST_RESP;
          end
        end
        default: begin
          if (resp_first) begin
            resp_q <= (mem_hit || ss_word_hit || restore_hit) ? 2'b00 : 2'b10;
            rdata  <= mem_hit ? {28'h0, host_rdata} : (ss_word_hit ? ss_rdata : 32'h0);
            bvalid <= write_q;
            rvalid <= !write_q;
          end else if ((bvalid && bready) || (rvalid && rready)) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            st     <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/shared_nibble_ram.sv
`timescale 1ns/1ps
`default_nettype none

module shared_nibble_ram import nibble_core_pkg::*; #(
  parameter int RAM_ADDR_BITS = 12
) (
  input  logic       clk,
  input  mem_req_t   core_req,
  input  mem_req_t   host_req,
  output logic [3:0] core_rdata,
  output logic [3:0] host_rdata,
  output logic       host_grant
);

  localparam int DEPTH = 2 ** RAM_ADDR_BITS;

  logic [3:0] mem [DEPTH];
  logic [RAM_ADDR_BITS-1:0] core_idx;
  logic [RAM_ADDR_BITS-1:0] host_idx;

  // Cleared by a sweep before first use
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 4'h0;
    end
  end

  assign core_idx = core_req.addr[RAM_ADDR_BITS-1:0];
  assign host_idx = host_req.addr[RAM_ADDR_BITS-1:0];

  // Core always wins
  assign host_grant = !core_req.valid;

  // Core reads are combinational
  assign core_rdata = mem[core_idx];

  always_ff @(posedge clk) begin
    if (core_req.valid) begin
      if (core_req.we) begin
        mem[core_idx] <= core_req.wdata;
      end
    end else if (host_grant && host_req.valid) begin
      if (host_req.we) begin
        mem[host_idx] <= host_req.wdata;
      end else begin
        host_rdata <= mem[host_idx];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/snapshot_port.sv
`timescale 1ns/1ps
`default_nettype none

module snapshot_port import nibble_core_pkg::*; #(
  parameter type        payload_t     = logic [31:0],
  parameter logic [7:0] ADDRESS       = 8'h00,
  parameter payload_t   DEFAULT_VALUE = '0
) (
  input  logic        clk,
  input  ss_bus_t     ss_bus,
  input  payload_t    current_data,
  output payload_t    new_data,
  output logic [31:0] bus_out
);

  logic addressed;

  // Power-up value matches a restore
  payload_t data_q = DEFAULT_VALUE;

  assign addressed = ss_bus.addr == ADDRESS;
  assign new_data  = data_q;
  assign bus_out   = addressed ? 32'(current_data) : 32'h0;

  always_ff @(posedge clk) begin
    if (ss_bus.restore) begin
      data_q <= DEFAULT_VALUE;
    end else if (ss_bus.wren && addressed) begin
      data_q <= payload_t'(ss_bus.wdata);
    end
  end

endmodule

`default_nettype wire

//--- hdl/core_regs.sv
`timescale 1ns/1ps
`default_nettype none

module core_regs import nibble_core_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  micro_step_t step,
  input  snap_regs1_t snap1_new,
  input  snap_regs2_t snap2_new,
  input  logic [3:0]  mem_rdata,
  output mem_req_t    core_req,
  output core_state_t state,
  output snap_regs1_t snap1_cur,
  output snap_regs2_t snap2_cur
);

  logic [3:0]  mux_out;
  logic        use_memory;
  logic [11:0] read_addr;
  logic [3:0]  bus_nibble;
  logic [11:0] pc_inc;
  logic [7:0]  sp_dec;
  logic        is_fetch;
  logic        store_dst;
  logic [11:0] store_ptr;
  logic        store_valid;
  logic [11:0] store_addr;
  logic [3:0]  store_data;

  reg_source_mux reg_source_mux_inst (
    .state       (state),
    .src         (step.src),
    .alu         (step.alu),
    .immed       (step.immed),
    .out         (mux_out),
    .use_memory  (use_memory),
    .memory_addr (read_addr)
  );

  assign bus_nibble = use_memory ? mem_rdata : mux_out;
  assign pc_inc     = state.pc[11:0] + 12'h1;
  assign sp_dec     = state.sp - 8'h1;
  assign is_fetch   = step.valid && step.cycle == CYCLE_FETCH;

  // Destination pointer of a store
  always_comb begin
    store_dst = 1'b1;
    store_ptr = 12'h000;
    case (step.dst)
      REG_MX:      store_ptr = state.x;
      REG_MY:      store_ptr = state.y;
      REG_MSP:     store_ptr = {4'h0, state.sp};
      REG_MSP_DEC: store_ptr = {4'h0, sp_dec};
      REG_MN:      store_ptr = {8'h00, step.immed[3:0]};
      default:     store_dst = 1'b0;
    endcase
  end

  // A pending store owns the port; reads never overlap it
  always_comb begin
    core_req.valid = store_valid || (step.valid && use_memory);
    core_req.we    = store_valid;
    core_req.addr  = store_valid ? store_addr : read_addr;
    core_req.wdata = store_data;
  end

  always_ff @(posedge clk) begin
    if (is_fetch && store_dst) begin
      store_addr <= store_ptr;
      store_data <= bus_nibble;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state.pc     <= snap1_new.pc;
      state.np     <= snap1_new.np;
      state.a      <= snap1_new.a;
      state.b      <= snap1_new.b;
      state.flags  <= snap1_new.flags;
      state.x      <= snap2_new.x;
      state.y      <= snap2_new.y;
      state.sp     <= snap2_new.sp;
      state.temp_a <= 4'h0;
      state.temp_b <= 4'h0;
      store_valid  <= 1'b0;
    end else begin
      store_valid <= is_fetch && store_dst;
      if (step.valid && step.cycle == CYCLE_WRITE) begin
        case (step.dst)
          REG_A:     state.a <= bus_nibble;
          REG_B:     state.b <= bus_nibble;
          REG_TEMPA: state.temp_a <= bus_nibble;
          REG_TEMPB: state.temp_b <= bus_nibble;
          REG_FLAGS: state.flags <= flags_t'(bus_nibble);
          REG_XL:    state.x[3:0] <= bus_nibble;
          REG_XH:    state.x[7:4] <= bus_nibble;
          REG_XP:    state.x[11:8] <= bus_nibble;
          REG_YL:    state.y[3:0] <= bus_nibble;
          REG_YH:    state.y[7:4] <= bus_nibble;
          REG_YP:    state.y[11:8] <= bus_nibble;
          REG_SPL:   state.sp[3:0] <= bus_nibble;
          REG_SPH:   state.sp[7:4] <= bus_nibble;
          REG_PCSL:  state.pc[3:0] <= bus_nibble;
          REG_PCSH:  state.pc[7:4] <= bus_nibble;
          REG_PCP:   state.pc[11:8] <= bus_nibble;
          REG_NPP:   state.np[3:0] <= bus_nibble;
          REG_NBP:   state.np[4] <= bus_nibble[0];
          default: ;
        endcase
        if (step.src == REG_ALU_WITH_FLAGS && step.dst != REG_FLAGS) begin
          state.flags.zero  <= step.alu_zero;
          state.flags.carry <= step.alu_carry;
        end
        // X and Y wrap inside their low byte
        case (step.inc)
          INC_XHL:    state.x[7:0] <= state.x[7:0] + 8'h1;
          INC_YHL:    state.y[7:0] <= state.y[7:0] + 8'h1;
          INC_SP_INC: state.sp <= state.sp + 8'h1;
          INC_SP_DEC: state.sp <= sp_dec;
          default: ;
        endcase
      end
      if (is_fetch) begin
        case (step.dst)
          REG_SETPC: state.pc <= {state.np, step.immed};
          REG_JPBAEND: begin
            state.pc[12:8] <= state.np;
            state.pc[3:0]  <= state.a;
          end
          default: ;
        endcase
        if (step.inc == INC_PC) begin
          state.pc[11:0] <= pc_inc;
        end
        if (step.reset_np) begin
          state.np <= state.pc[12:8];
        end
      end
      if (step.valid && step.increment_pc) begin
        state.pc[11:0] <= pc_inc;
      end
    end
  end

  assign snap1_cur = '{pad: 2'b00, np: state.np, pc: state.pc, a: state.a, b: state.b,
                       flags: state.flags};
  assign snap2_cur = '{x: state.x, y: state.y, sp: state.sp};

endmodule

`default_nettype wire

//--- hdl/reg_source_mux.sv
`timescale 1ns/1ps
`default_nettype none

module reg_source_mux import nibble_core_pkg::*; (
  input  core_state_t state,
  input  reg_sel_e    src,
  input  logic [3:0]  alu,
  input  logic [7:0]  immed,
  output logic [3:0]  out,
  output logic        use_memory,
  output logic [11:0] memory_addr
);

  logic [7:0] sp_dec;

  assign sp_dec = state.sp - 8'h1;

  always_comb begin
    out = 4'h0;
    case (src)
      REG_A:              out = state.a;
      REG_B:              out = state.b;
      REG_TEMPA:          out = state.temp_a;
      REG_TEMPB:          out = state.temp_b;
      REG_FLAGS:          out = state.flags;
      REG_XL:             out = state.x[3:0];
      REG_XH:             out = state.x[7:4];
      REG_XP:             out = state.x[11:8];
      REG_YL:             out = state.y[3:0];
      REG_YH:             out = state.y[7:4];
      REG_YP:             out = state.y[11:8];
      REG_SPL:            out = state.sp[3:0];
      REG_SPH:            out = state.sp[7:4];
      REG_PCSL:           out = state.pc[3:0];
      REG_PCSH:           out = state.pc[7:4];
      REG_PCP:            out = state.pc[11:8];
      REG_NPP:            out = state.np[3:0];
      REG_NBP:            out = {3'b000, state.np[4]};
      REG_ALU:            out = alu;
      REG_ALU_WITH_FLAGS: out = alu;
      REG_IMML:           out = immed[3:0];
      REG_IMMH:           out = immed[7:4];
      default:            out = 4'h0;
    endcase
  end

  // Pointer for memory sources
  always_comb begin
    use_memory  = 1'b1;
    memory_addr = 12'h000;
    case (src)
      REG_MX:      memory_addr = state.x;
      REG_MY:      memory_addr = state.y;
      REG_MSP:     memory_addr = {4'h0, state.sp};
      REG_MSP_DEC: memory_addr = {4'h0, sp_dec};
      REG_MN:      memory_addr = {8'h00, immed[3:0]};
      default:     use_memory = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/nibble_core_pkg.sv
`default_nettype none

package nibble_core_pkg;

  typedef enum logic {
    CYCLE_FETCH,
    CYCLE_WRITE
  } cycle_e;

  typedef enum logic [4:0] {
    REG_A, REG_B, REG_TEMPA, REG_TEMPB, REG_FLAGS,
    REG_XL, REG_XH, REG_XP, REG_YL, REG_YH, REG_YP,
    REG_SPL, REG_SPH, REG_PCSL, REG_PCSH, REG_PCP, REG_NPP, REG_NBP,
    REG_MX, REG_MY, REG_MSP, REG_MSP_DEC, REG_MN,
    // Source only
    REG_ALU, REG_ALU_WITH_FLAGS, REG_IMML, REG_IMMH,
    // Destination only
    REG_SETPC, REG_JPBAEND
  } reg_sel_e;

  typedef enum logic [2:0] {
    INC_NONE, INC_PC, INC_XHL, INC_YHL, INC_SP_INC, INC_SP_DEC
  } inc_sel_e;

  typedef struct packed {
    logic       valid;
    cycle_e     cycle;
    reg_sel_e   src;
    reg_sel_e   dst;
    inc_sel_e   inc;
    logic       increment_pc;
    logic       reset_np;
    logic [3:0] alu;
    logic       alu_zero;
    logic       alu_carry;
    logic [7:0] immed;
  } micro_step_t;

  // High bit to low bit as seen on the register bus
  typedef struct packed {
    logic interrupt;
    logic decimal;
    logic zero;
    logic carry;
  } flags_t;

  typedef struct packed {
    logic [12:0] pc;
    logic [4:0]  np;
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  temp_a;
    logic [3:0]  temp_b;
    logic [11:0] x;
    logic [11:0] y;
    logic [7:0]  sp;
    flags_t      flags;
  } core_state_t;

  typedef struct packed {
    logic [1:0]  pad;
    logic [4:0]  np;
    logic [12:0] pc;
    logic [3:0]  a;
    logic [3:0]  b;
    flags_t      flags;
  } snap_regs1_t;

  typedef struct packed {
    logic [11:0] x;
    logic [11:0] y;
    logic [7:0]  sp;
  } snap_regs2_t;

  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic        wren;
    logic        restore;
  } ss_bus_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    logic [11:0] addr;
    logic [3:0]  wdata;
  } mem_req_t;

  localparam logic [7:0] SS_REGS1 = 8'h00;
  localparam logic [7:0] SS_REGS2 = 8'h01;

  // Boot on page 1
  localparam snap_regs1_t SNAP1_DEFAULT = '{
    pad: 2'b00, np: 5'h01, pc: 13'h0100, a: 4'h0, b: 4'h0, flags: 4'h0
  };

endpackage

`default_nettype wire
